// ==== Bender.yml ====
package:
  name: nco

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/nco_pkg.sv
      - src/nco_cfg_if.sv
      - src/nco_ctrl.sv
      - src/nco_phase_acc.sv
      - src/nco_pulse_gen.sv
      - src/nco_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - tests/nco_checker.sv
      - tests/nco_tb.sv

// ==== files.f ====
+incdir+src
src/nco_pkg.sv
src/nco_cfg_if.sv
src/nco_ctrl.sv
src/nco_phase_acc.sv
src/nco_pulse_gen.sv
src/nco_top.sv
tests/nco_checker.sv
tests/nco_tb.sv

// ==== src/nco_cfg_if.sv ====
/*
 * Configuration bundle from the NCO controller to the datapath blocks.
 * The controller drives it through ctrl, the datapath reads it through dp.
 */
`default_nettype none

interface nco_cfg_if;
   import nco_pkg::*;

   // holds the datapath cleared while set
   logic        soft_reset;
   logic        enable;
   // joined period, valid during period_load
   nco_period_t period;
   // one-cycle strobe per completed period pair
   logic        period_load;

   modport ctrl (
      output soft_reset,
      output enable,
      output period,
      output period_load
   );

   modport dp (
      input soft_reset,
      input enable,
      input period,
      input period_load
   );

endinterface

`default_nettype wire

// ==== src/nco_ctrl.sv ====
/*
 * NCO register file: decodes strobed writes, tracks the two period halves
 * and issues a single load pulse once both halves have been written.
 */
`default_nettype none

`include "nco_macros.svh"

module nco_ctrl (
   input  wire                    clk_i,
   input  wire                    rst_n_i,
   input  wire                    wr_en_i,
   input  wire nco_pkg::nco_addr_e wr_addr_i,
   input  wire [7:0]              wr_data_i,
   nco_cfg_if.ctrl                cfg
);
   import nco_pkg::*;

   logic [`NCO_INT_W-1:0]  int_q;
   logic [`NCO_FRAC_W-1:0] frac_q;
   logic                   int_mark_q;
   logic                   frac_mark_q;
   logic                   enable_q;
   logic                   soft_reset_q;

   logic wr_soft_reset;
   logic wr_enable;
   logic wr_int;
   logic wr_frac;
   logic pair_done;

   // address decode, period halves locked out during soft reset
   always_comb begin
      wr_soft_reset = 1'b0;
      wr_enable     = 1'b0;
      wr_int        = 1'b0;
      wr_frac       = 1'b0;
      if (wr_en_i) begin
         case (wr_addr_i)
            NCO_ADDR_SOFT_RESET:  wr_soft_reset = 1'b1;
            NCO_ADDR_ENABLE:      wr_enable     = 1'b1;
            NCO_ADDR_PERIOD_INT:  wr_int        = ~soft_reset_q;
            NCO_ADDR_PERIOD_FRAC: wr_frac       = ~soft_reset_q;
            default:              wr_enable     = 1'b0;
         endcase
      end
   end

   assign pair_done = int_mark_q & frac_mark_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         soft_reset_q <= 1'b0;
         enable_q     <= 1'b0;
      end else begin
         if (wr_soft_reset) begin
            soft_reset_q <= wr_data_i[0];
         end
         // enable is dropped by soft reset and must be written again
         if (soft_reset_q) begin
            enable_q <= 1'b0;
         end else if (wr_enable) begin
            enable_q <= wr_data_i[0];
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         int_q       <= '0;
         frac_q      <= '0;
         int_mark_q  <= 1'b0;
         frac_mark_q <= 1'b0;
      end else if (soft_reset_q) begin
         int_q       <= '0;
         frac_q      <= '0;
         int_mark_q  <= 1'b0;
         frac_mark_q <= 1'b0;
      end else begin
         if (wr_int) begin
            int_q <= wr_data_i[`NCO_INT_W-1:0];
         end
         if (wr_frac) begin
            frac_q <= wr_data_i[`NCO_FRAC_W-1:0];
         end
         // pair consumed this cycle, a write landing now starts the next pair
         if (pair_done) begin
            int_mark_q  <= wr_int;
            frac_mark_q <= wr_frac;
         end else begin
            int_mark_q  <= int_mark_q | wr_int;
            frac_mark_q <= frac_mark_q | wr_frac;
         end
      end
   end

   assign cfg.soft_reset  = soft_reset_q;
   assign cfg.enable      = enable_q & ~soft_reset_q;
   assign cfg.period      = {int_q, frac_q};
   assign cfg.period_load = pair_done & ~soft_reset_q;

endmodule

`default_nettype wire

// ==== src/nco_macros.svh ====
/*
 * Width definitions for the NCO fixed-point period and register port.
 * Include wherever a field width is needed.
 */
`ifndef NCO_MACROS_SVH
`define NCO_MACROS_SVH

// integer part of the period, in clk_i cycles
`define NCO_INT_W 8

// fractional part of the period
`define NCO_FRAC_W 8

// full fixed-point period
`define NCO_PERIOD_W (`NCO_INT_W + `NCO_FRAC_W)

// register address
`define NCO_ADDR_W 2

`endif

// ==== src/nco_phase_acc.sv ====
/*
 * Fixed-point phase accumulator and rounding quantizer.
 * quant_o is the integer length of the output period now running.
 */
`default_nettype none

`include "nco_macros.svh"

module nco_phase_acc (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   nco_cfg_if.dp                 cfg,
   input  wire                   wrap_i,
   output logic [`NCO_INT_W-1:0] quant_o
);
   import nco_pkg::*;

   nco_period_t              period_q;
   logic [`NCO_PERIOD_W-1:0] acc_q;
   logic [`NCO_PERIOD_W-1:0] acc_step;
   logic [`NCO_INT_W-1:0]    acc_int;
   logic [`NCO_FRAC_W-1:0]   acc_frac;
   logic                     frac_half;

   assign acc_int   = acc_q[`NCO_PERIOD_W-1:`NCO_FRAC_W];
   assign acc_frac  = acc_q[`NCO_FRAC_W-1:0];
   assign frac_half = (acc_frac == {1'b1, {(`NCO_FRAC_W-1){1'b0}}});

   // round to nearest, ties go up only on odd parity of the integer part
   always_comb begin
      if (frac_half) begin
         quant_o = acc_int + {{(`NCO_INT_W-1){1'b0}}, ^acc_int};
      end else if (acc_frac[`NCO_FRAC_W-1]) begin
         quant_o = acc_int + 1'b1;
      end else begin
         quant_o = acc_int;
      end
   end

   // add one period and take away what was spent
   assign acc_step = period_q - {quant_o, {`NCO_FRAC_W{1'b0}}};

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         period_q <= '0;
         acc_q    <= '0;
      end else if (cfg.soft_reset) begin
         period_q <= '0;
         acc_q    <= '0;
      end else if (cfg.period_load) begin
         period_q <= cfg.period;
         acc_q    <= cfg.period;
      end else if (wrap_i) begin
         acc_q <= acc_q + acc_step;
      end
   end

endmodule

`default_nettype wire

// ==== src/nco_pkg.sv ====
/*
 * Shared NCO types: register addresses and the fixed-point period.
 */
`default_nettype none

`include "nco_macros.svh"

package nco_pkg;

   // write-port register map, also used as the opcode set
   typedef enum logic [`NCO_ADDR_W-1:0] {
      NCO_ADDR_SOFT_RESET  = 2'd0,
      NCO_ADDR_ENABLE      = 2'd1,
      NCO_ADDR_PERIOD_INT  = 2'd2,
      NCO_ADDR_PERIOD_FRAC = 2'd3
   } nco_addr_e;

   // integer part in the high byte, fraction in the low byte
   typedef struct packed {
      logic [`NCO_INT_W-1:0]  integ;
      logic [`NCO_FRAC_W-1:0] frac;
   } nco_period_t;

endpackage

`default_nettype wire

// ==== src/nco_pulse_gen.sv ====
/*
 * Modulo counter and registered output clock.
 * High during the later half of each count, wrap_o flags the last count.
 */
`default_nettype none

`include "nco_macros.svh"

module nco_pulse_gen (
   input  wire                  clk_i,
   input  wire                  rst_n_i,
   nco_cfg_if.dp                cfg,
   input  wire [`NCO_INT_W-1:0] quant_i,
   output logic                 wrap_o,
   output logic                 clk_out_o
);

   logic [`NCO_INT_W-1:0] cnt_q;
   logic [`NCO_INT_W-1:0] last_cnt;

   assign last_cnt = quant_i - 1'b1;
   assign wrap_o   = cfg.enable & (cnt_q == last_cnt);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (cfg.soft_reset || cfg.period_load) begin
         cnt_q <= '0;
      end else if (cfg.enable) begin
         if (cnt_q == last_cnt) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // holds its level while disabled
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         clk_out_o <= 1'b0;
      end else if (cfg.soft_reset) begin
         clk_out_o <= 1'b0;
      end else if (cfg.enable) begin
         clk_out_o <= (cnt_q > (quant_i >> 1));
      end
   end

endmodule

`default_nettype wire

// ==== src/nco_top.sv ====
/*
 * NCO top level: write port in, clk_out_o out.
 * Joins the controller with the accumulator and the pulse generator.
 */
`default_nettype none

`include "nco_macros.svh"

module nco_top (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   input  wire                   wr_en_i,
   input  wire [`NCO_ADDR_W-1:0] wr_addr_i,
   input  wire [7:0]             wr_data_i,
   output logic                  clk_out_o
);
   import nco_pkg::*;

   logic [`NCO_INT_W-1:0] quant;
   logic                  wrap;

   nco_cfg_if cfg_if ();

   nco_ctrl u_ctrl (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (wr_en_i),
      .wr_addr_i(nco_addr_e'(wr_addr_i)),
      .wr_data_i(wr_data_i),
      .cfg      (cfg_if.ctrl)
   );

   nco_phase_acc u_phase_acc (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .cfg    (cfg_if.dp),
      .wrap_i (wrap),
      .quant_o(quant)
   );

   nco_pulse_gen u_pulse_gen (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .cfg      (cfg_if.dp),
      .quant_i  (quant),
      .wrap_o   (wrap),
      .clk_out_o(clk_out_o)
   );

endmodule

`default_nettype wire

// ==== tests/nco_checker.sv ====
/*
 * Cycle model of the NCO register port and datapath, run beside the DUT.
 * Compares clk_out_o every cycle and counts mismatches and output rising edges.
 */
`default_nettype none

`include "nco_macros.svh"

module nco_checker (
   input  wire                   clk_i,
   input  wire                   rst_n_i,
   input  wire                   wr_en_i,
   input  wire [`NCO_ADDR_W-1:0] wr_addr_i,
   input  wire [7:0]             wr_data_i,
   input  wire                   clk_out_i,
   output int                    compare_cnt_o,
   output int                    mismatch_cnt_o,
   output int                    rise_cnt_o
);
   import nco_pkg::*;

   logic                     soft_m;
   logic                     en_m;
   logic [`NCO_INT_W-1:0]    int_m;
   logic [`NCO_FRAC_W-1:0]   frac_m;
   logic                     int_mk_m;
   logic                     frac_mk_m;
   logic [`NCO_PERIOD_W-1:0] per_m;
   logic [`NCO_PERIOD_W-1:0] acc_m;
   logic [`NCO_INT_W-1:0]    cnt_m;
   logic                     clk_m;
   logic                     clk_out_prev;

   // nearest integer, an exact half goes up only for odd parity
   function automatic logic [`NCO_INT_W-1:0] round_period(input logic [`NCO_PERIOD_W-1:0] acc);
      logic [`NCO_INT_W-1:0]  whole;
      logic [`NCO_FRAC_W-1:0] frac;
      logic [`NCO_FRAC_W-1:0] half;
      whole = acc[`NCO_PERIOD_W-1:`NCO_FRAC_W];
      frac  = acc[`NCO_FRAC_W-1:0];
      half  = 1 << (`NCO_FRAC_W - 1);
      if (frac > half || (frac == half && (^whole))) begin
         return whole + 1'b1;
      end
      return whole;
   endfunction

   always @(posedge clk_i or negedge rst_n_i) begin : ref_model
      logic                  go;
      logic                  load;
      logic                  wr_int;
      logic                  wr_frac;
      logic [`NCO_INT_W-1:0] q;
      logic [`NCO_INT_W-1:0] last;
      if (!rst_n_i) begin
         {soft_m, en_m, int_m, frac_m, int_mk_m, frac_mk_m} <= '0;
         {per_m, acc_m, cnt_m, clk_m} <= '0;
      end else begin
         go      = en_m && !soft_m;
         load    = int_mk_m && frac_mk_m && !soft_m;
         wr_int  = wr_en_i && wr_addr_i == NCO_ADDR_PERIOD_INT && !soft_m;
         wr_frac = wr_en_i && wr_addr_i == NCO_ADDR_PERIOD_FRAC && !soft_m;
         q       = round_period(acc_m);
         last    = q - 1'b1;
         if (wr_en_i && wr_addr_i == NCO_ADDR_SOFT_RESET) begin
            soft_m <= wr_data_i[0];
         end
         if (soft_m) begin
            en_m <= 1'b0;
         end else if (wr_en_i && wr_addr_i == NCO_ADDR_ENABLE) begin
            en_m <= wr_data_i[0];
         end
         if (soft_m) begin
            {int_m, frac_m, int_mk_m, frac_mk_m} <= '0;
            {per_m, acc_m, cnt_m, clk_m} <= '0;
         end else begin
            if (wr_int) int_m <= wr_data_i;
            if (wr_frac) frac_m <= wr_data_i;
            // a load consumes the pair, a write in the same cycle still counts
            int_mk_m  <= wr_int || (int_mk_m && !load);
            frac_mk_m <= wr_frac || (frac_mk_m && !load);
            if (load) begin
               per_m <= {int_m, frac_m};
               acc_m <= {int_m, frac_m};
               cnt_m <= '0;
            end else if (go && cnt_m == last) begin
               cnt_m <= '0;
               acc_m <= acc_m + per_m - {q, {`NCO_FRAC_W{1'b0}}};
            end else if (go) begin
               cnt_m <= cnt_m + 1'b1;
            end
            if (go) clk_m <= cnt_m > (q / 2);
         end
      end
   end

   initial begin
      compare_cnt_o  = 0;
      mismatch_cnt_o = 0;
      rise_cnt_o     = 0;
      clk_out_prev   = 1'b0;
   end

   // outputs settled half a cycle after the edge
   always @(negedge clk_i) begin
      compare_cnt_o = compare_cnt_o + 1;
      if (clk_out_i !== clk_m) begin
         mismatch_cnt_o = mismatch_cnt_o + 1;
         $display("** Error clk_out_o: expected 0x%h, actual 0x%h at time %0t",
                  clk_m, clk_out_i, $time);
      end
      if (clk_out_i && !clk_out_prev) rise_cnt_o = rise_cnt_o + 1;
      clk_out_prev = clk_out_i;
   end

endmodule

`default_nettype wire

// ==== tests/nco_tb.sv ====
/*
 * Testbench for nco_top with clock, reset and LFSR-driven register writes.
 * nco_checker models the DUT and compares clk_out_o every cycle.
 */
`default_nettype none

`include "nco_macros.svh"

module nco_tb;
   import nco_pkg::*;

   localparam int PHASE_COUNT      = 6;
   localparam int PHASE_MAX_CYCLES = 400;
   // phase budget plus margin for random gaps
   localparam int CYCLE_LIMIT      = PHASE_COUNT * PHASE_MAX_CYCLES + 1600;

   logic                   clk_i = 1'b0;
   logic                   rst_n_i;
   logic                   wr_en_i;
   logic [`NCO_ADDR_W-1:0] wr_addr_i;
   logic [7:0]             wr_data_i;
   logic                   clk_out_o;
   logic [15:0]            lfsr_state;
   int                     cycle_cnt = 0;
   int                     other_errs;
   int                     compare_cnt;
   int                     mismatch_cnt;
   int                     rise_cnt;

   nco_top UUT (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (wr_en_i),
      .wr_addr_i(wr_addr_i),
      .wr_data_i(wr_data_i),
      .clk_out_o(clk_out_o)
   );

   nco_checker u_checker (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .wr_en_i       (wr_en_i),
      .wr_addr_i     (wr_addr_i),
      .wr_data_i     (wr_data_i),
      .clk_out_i     (clk_out_o),
      .compare_cnt_o (compare_cnt),
      .mismatch_cnt_o(mismatch_cnt),
      .rise_cnt_o    (rise_cnt)
   );

   always #4 clk_i = ~clk_i;

   // galois form with taps x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val        = {val[14:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk_i);
   endtask

   task automatic write_reg(input logic [`NCO_ADDR_W-1:0] addr, input logic [7:0] data);
      @(posedge clk_i);
      wr_en_i   <= 1'b1;
      wr_addr_i <= addr;
      wr_data_i <= data;
      @(posedge clk_i);
      wr_en_i   <= 1'b0;
   endtask

   // halves in random order with random gaps
   task automatic write_period(input logic [7:0] integ, input logic [7:0] frac);
      logic [15:0] order;
      logic [15:0] gap;
      draw_bits(1, order);
      draw_bits(3, gap);
      idle_cycles(gap);
      write_reg(order[0] ? NCO_ADDR_PERIOD_FRAC : NCO_ADDR_PERIOD_INT, order[0] ? frac : integ);
      draw_bits(3, gap);
      idle_cycles(gap);
      write_reg(order[0] ? NCO_ADDR_PERIOD_INT : NCO_ADDR_PERIOD_FRAC, order[0] ? integ : frac);
   endtask

   task automatic draw_integer(output logic [7:0] integ);
      logic [15:0] r;
      draw_bits(4, r);
      integ = (r[3:0] < 2) ? r[7:0] + 8'd2 : r[7:0];
   endtask

   task automatic report_counts(input int timeouts);
      $display("Checks: %0d, value errors: %0d, other errors: %0d, timeouts: %0d",
               compare_cnt, mismatch_cnt, other_errs, timeouts);
   endtask

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         report_counts(1);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin : stimulus
      logic [15:0] r;
      logic [7:0]  integ;
      rst_n_i    = 1'b0;
      wr_en_i    = 1'b0;
      wr_addr_i  = '0;
      wr_data_i  = '0;
      other_errs = 0;
      lfsr_state = 16'd21713;
      repeat (5) @(posedge clk_i);
      rst_n_i <= 1'b1;
      // output stays low without writes
      idle_cycles(20);
      // integer-only periods
      repeat (2) begin
         draw_integer(integ);
         write_period(integ, 8'h00);
         write_reg(NCO_ADDR_ENABLE, 8'h01);
         idle_cycles(60);
      end
      // random fractional periods
      repeat (4) begin
         draw_integer(integ);
         draw_bits(8, r);
         write_period(integ, r[7:0]);
         idle_cycles(70);
      end
      // exact half fraction exercises the parity tie
      draw_integer(integ);
      write_period(integ, 8'h80);
      idle_cycles(60);
      // freeze mid-period and resume
      draw_bits(3, r);
      idle_cycles(r);
      write_reg(NCO_ADDR_ENABLE, 8'h00);
      draw_bits(3, r);
      idle_cycles(r + 5);
      write_reg(NCO_ADDR_ENABLE, 8'h01);
      idle_cycles(40);
      // soft reset drops the half-written pair
      draw_integer(integ);
      write_reg(NCO_ADDR_PERIOD_INT, integ);
      write_reg(NCO_ADDR_SOFT_RESET, 8'h01);
      write_reg(NCO_ADDR_PERIOD_FRAC, 8'h40);
      idle_cycles(5);
      write_reg(NCO_ADDR_SOFT_RESET, 8'h00);
      draw_bits(8, r);
      write_reg(NCO_ADDR_PERIOD_FRAC, r[7:0]);
      idle_cycles(10);
      draw_integer(integ);
      write_reg(NCO_ADDR_PERIOD_INT, integ);
      write_reg(NCO_ADDR_ENABLE, 8'h01);
      idle_cycles(80);
      if (rise_cnt == 0) begin
         $display("clk_out_o never rose during the run");
         other_errs = other_errs + 1;
      end
      report_counts(0);
      if (mismatch_cnt == 0 && other_errs == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
